/* sim.f */
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/regfile.sv
rtl/decode_unit.sv
rtl/hazard_unit.sv
rtl/execute_unit.sv
rtl/memory_writeback.sv
rtl/core_top.sv
test/core_tb.sv

/* test/core_tb.sv */
// rv64 core testbench
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic [xlen-1:0] imem_addr;
	logic [31:0] imem_data;
	logic [xlen-1:0] dmem_addr;
	logic [xlen-1:0] dmem_wdata;
	logic dmem_wena;
	logic [xlen-1:0] dmem_rdata;
	commit_t commit;

	logic [31:0] imem [256];
	logic [63:0] dmem [32];
	logic [31:0] lfsr = 32'h871c5ee0;
	int prog_len;
	commit_t expected [$];
	commit_t exp_entry;
	logic [63:0] exp_store_addr [$];
	logic [63:0] exp_store_data [$];
	bit done = 1'b0;
	bit fetch_checked = 1'b0;

	core_top core_top_i (
		.clock(clock),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_wena(dmem_wena),
		.dmem_rdata(dmem_rdata),
		.commit(commit)
	);

	always #20 clock = ~clock;

	// combinational-read memories, doubleword data
	assign imem_data = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[7:3]];

	always @(posedge clock) begin
		if (dmem_wena)
			dmem[dmem_addr[7:3]] <= dmem_wdata;
	end

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [31:0] v;
		v = random_bits(5);
		return (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
	endfunction

	// unknown opcode past the end of the program
	function automatic logic [31:0] filler_word(int idx);
		return {25'(idx * 4) ^ 25'h15a5a5a, 7'h7f};
	endfunction

	function automatic logic [63:0] fill_dword(int idx);
		return {32'(idx * 8) ^ 32'hc3a596e1, 32'(idx * 8) * 32'h9e3779b1};
	endfunction

	function automatic logic [31:0] enc_i(logic [6:0] opcode, logic [2:0] funct3,
			logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		inst_t w;
		w.i_fmt = '{imm, rs1, funct3, rd, opcode};
		return w;
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] funct7, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		inst_t w;
		w.r_fmt = '{funct7, rs2, rs1, 3'd0, rd, op_reg};
		return w;
	endfunction

	function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
		inst_t w;
		w.s_fmt = '{imm[11:5], rs2, rs1, 3'd3, imm[4:0], op_store};
		return w;
	endfunction

	function automatic logic [31:0] enc_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
		inst_t w;
		w.b_fmt = '{off[12], off[10:5], rs2, rs1, 3'd0, off[4:1], off[11], op_branch};
		return w;
	endfunction

	task automatic emit(logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic build_program();
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rc;
		logic [4:0] rd;
		logic [4:0] rn;
		logic [11:0] imm;
		logic [11:0] off;
		int start;
		int step;
		int kind;
		for (int i = 0; i < 256; i++)
			imem[i] = filler_word(i);
		prog_len = 0;
		for (int r = 0; r < 6; r++) begin
			// step below 5 makes each round a permutation of the groups
			start = random_bits(3) % 5;
			step = random_bits(2) + 1;
			for (int k = 0; k < 5; k++) begin
				kind = (start + k * step) % 5;
				ra = pick_reg();
				rb = pick_reg();
				rc = pick_reg();
				rd = pick_reg();
				rn = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
				imm = 12'(random_bits(12));
				off = 12'(random_bits(5) << 3);
				case (kind)
					0: begin
						emit(enc_i(op_imm, 3'd0, ra, rb, imm));
						emit(enc_r(7'd0, rc, ra, rb));
						emit(enc_r(funct_sub, rd, rc, ra));
					end
					1: begin
						emit(enc_s(5'd0, ra, off));
						emit(enc_i(op_load, 3'd3, rb, 5'd0, off));
						emit(enc_r(7'd0, rc, rb, ra));
					end
					2: begin
						// taken, skips the two addi
						emit(enc_r(7'd0, rb, ra, 5'd0));
						emit(enc_b(ra, rb, 13'd12));
						emit(enc_i(op_imm, 3'd0, rc, rc, imm));
						emit(enc_i(op_imm, 3'd0, rd, rd, imm));
					end
					3: begin
						emit(enc_i(op_imm, 3'd0, ra, 5'd0, imm));
						emit(enc_i(op_imm, 3'd0, rn, ra, 12'd1));
						emit(enc_b(ra, rn, 13'd8));
						emit(enc_i(op_imm, 3'd0, rc, ra, imm));
					end
					default: begin
						emit(enc_i(op_imm, 3'd0, 5'd0, ra, imm));
						emit(enc_r(7'd0, rb, 5'd0, ra));
					end
				endcase
			end
		end
		// self-loop ends the program
		emit(enc_b(5'd0, 5'd0, 13'd0));
	endtask

	// sequential ISA model, fills the expected commit stream
	task automatic run_model();
		inst_t w;
		commit_t entry;
		logic [63:0] regs [32];
		logic [63:0] model_mem [32];
		logic [63:0] pc;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] addr;
		logic [63:0] br_off;
		bit halted;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
			model_mem[i] = fill_dword(i);
		end
		pc = reset_pc;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 1000) begin
			w = imem[pc[9:2]];
			a = regs[w.r_fmt.rs1];
			b = regs[w.r_fmt.rs2];
			entry = '0;
			entry.valid = 1'b1;
			entry.pc = pc;
			addr = a + {{52{w.i_fmt.imm[11]}}, w.i_fmt.imm};
			br_off = {{51{w.b_fmt.imm12}}, w.b_fmt.imm12, w.b_fmt.imm11, w.b_fmt.imm10_5,
				w.b_fmt.imm4_1, 1'b0};
			pc = pc + 64'd4;
			case (w.r_fmt.opcode)
				op_imm: begin
					entry.rd_wena = 1'b1;
					entry.data = addr;
				end
				op_reg: begin
					entry.rd_wena = 1'b1;
					entry.data = (w.r_fmt.funct7 == funct_sub) ? a - b : a + b;
				end
				op_load: begin
					entry.rd_wena = 1'b1;
					entry.data = model_mem[addr[7:3]];
				end
				op_store: begin
					addr = a + {{52{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
					model_mem[addr[7:3]] = b;
					exp_store_addr.push_back(addr);
					exp_store_data.push_back(b);
				end
				op_branch: begin
					if (a == b) begin
						halted = (br_off == '0);
						pc = entry.pc + br_off;
					end
				end
				default: ;
			endcase
			if (entry.rd_wena) begin
				entry.rd = w.r_fmt.rd;
				if (entry.rd != '0)
					regs[entry.rd] = entry.data;
			end
			expected.push_back(entry);
			steps++;
		end
	endtask

	task automatic stop_with_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_field(string name, logic [63:0] got, logic [63:0] want);
		assert (got === want) else begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
			stop_with_failure();
		end
	endtask

	// each data write must be the next store of the model
	task automatic check_store();
		if (exp_store_addr.size() == 0) begin
			$display("Unexpected store to %h at %0t ns", dmem_addr, $time);
			stop_with_failure();
		end
		check_field("dmem_wena", dmem_wena, 64'd1);
		check_field("dmem_addr", dmem_addr, exp_store_addr.pop_front());
		check_field("dmem_wdata", dmem_wdata, exp_store_data.pop_front());
	endtask

	// outputs sampled mid-cycle, away from the driving edge
	always @(negedge clock) begin
		if (reset) begin
			check_field("commit.valid", commit.valid, 64'd0);
			check_field("dmem_wena", dmem_wena, 64'd0);
		end else if (!fetch_checked) begin
			fetch_checked = 1'b1;
			check_field("imem_addr", imem_addr, reset_pc);
			check_field("commit.valid", commit.valid, 64'd0);
			check_field("dmem_wena", dmem_wena, 64'd0);
		end else begin
			if (dmem_wena !== 1'b0)
				check_store();
			if (!done && commit.valid !== 1'b0) begin
				check_field("commit.valid", commit.valid, 64'd1);
				exp_entry = expected.pop_front();
				check_field("commit.pc", commit.pc, exp_entry.pc);
				check_field("commit.rd_wena", commit.rd_wena, exp_entry.rd_wena);
				if (exp_entry.rd_wena) begin
					check_field("commit.rd", commit.rd, exp_entry.rd);
					check_field("commit.data", commit.data, exp_entry.data);
				end
				if (expected.size() == 0)
					done = 1'b1;
			end
		end
	end

	initial begin
		int cycles;
		build_program();
		for (int i = 0; i < 32; i++)
			dmem[i] = fill_dword(i);
		run_model();
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		cycles = 0;
		while (!done && cycles < 4000) begin
			@(posedge clock);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: core stopped retiring with %0d commits still expected",
				expected.size());
			stop_with_failure();
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

/* rtl/core_top.sv */
// five-stage rv64 core
`timescale 1ns/100ps

module core_top import core_pkg::*; (
	input logic clock,
	input logic reset,
	output logic [xlen-1:0] imem_addr,
	input logic [31:0] imem_data,
	output logic [xlen-1:0] dmem_addr,
	output logic [xlen-1:0] dmem_wdata,
	output logic dmem_wena,
	input logic [xlen-1:0] dmem_rdata,
	output commit_t commit
);

	if_id_t if_id;
	id_ex_t id_ex;
	ex_me_t ex_me;
	me_wb_t me_wb;

	logic stall;
	logic redirect;
	logic [xlen-1:0] redirect_pc;
	logic [reg_addr_width-1:0] rs1;
	logic [reg_addr_width-1:0] rs2;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	fwd_sel_t rs1_sel;
	fwd_sel_t rs2_sel;

	fetch_unit fetch_unit_i (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.if_id(if_id)
	);

	regfile regfile_i (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wena(me_wb.valid & me_wb.rd_wena),
		.waddr(me_wb.rd),
		.wdata(me_wb.result)
	);

	decode_unit decode_unit_i (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.if_id(if_id),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.id_ex(id_ex)
	);

	hazard_unit hazard_unit_i (
		.rs1(rs1),
		.rs2(rs2),
		.decode_valid(if_id.valid),
		.id_ex(id_ex),
		.ex_me(ex_me),
		.me_wb(me_wb),
		.stall(stall),
		.rs1_sel(rs1_sel),
		.rs2_sel(rs2_sel)
	);

	execute_unit execute_unit_i (
		.clock(clock),
		.reset(reset),
		.id_ex(id_ex),
		.rs1_sel(rs1_sel),
		.rs2_sel(rs2_sel),
		.mem_result(ex_me.alu_result),
		.wb_result(me_wb.result),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_me(ex_me)
	);

	memory_writeback memory_writeback_i (
		.clock(clock),
		.reset(reset),
		.ex_me(ex_me),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_wena(dmem_wena),
		.dmem_rdata(dmem_rdata),
		.me_wb(me_wb),
		.commit(commit)
	);

endmodule

/* rtl/memory_writeback.sv */
// data memory access and writeback
`timescale 1ns/100ps

module memory_writeback import core_pkg::*; (
	input logic clock,
	input logic reset,
	input ex_me_t ex_me,
	output logic [xlen-1:0] dmem_addr,
	output logic [xlen-1:0] dmem_wdata,
	output logic dmem_wena,
	input logic [xlen-1:0] dmem_rdata,
	output me_wb_t me_wb,
	output commit_t commit
);

	assign dmem_addr = ex_me.alu_result;
	assign dmem_wdata = ex_me.store_data;
	assign dmem_wena = ex_me.valid && ex_me.is_store;

	always_ff @(posedge clock) begin
		if (reset) begin
			me_wb.valid <= 1'b0;
			me_wb.rd_wena <= 1'b0;
		end else begin
			me_wb.valid <= ex_me.valid;
			me_wb.rd_wena <= ex_me.rd_wena;
			me_wb.pc <= ex_me.pc;
			me_wb.rd <= ex_me.rd;
			me_wb.result <= ex_me.is_load ? dmem_rdata : ex_me.alu_result;
		end
	end

	// retire in the same cycle as the register write
	assign commit.valid = me_wb.valid;
	assign commit.pc = me_wb.pc;
	assign commit.rd_wena = me_wb.rd_wena;
	assign commit.rd = me_wb.rd;
	assign commit.data = me_wb.result;

endmodule

/* rtl/execute_unit.sv */
// execute stage with branch resolve
`timescale 1ns/100ps

module execute_unit import core_pkg::*; (
	input logic clock,
	input logic reset,
	input id_ex_t id_ex,
	input fwd_sel_t rs1_sel,
	input fwd_sel_t rs2_sel,
	input logic [xlen-1:0] mem_result,
	input logic [xlen-1:0] wb_result,
	output logic redirect,
	output logic [xlen-1:0] redirect_pc,
	output ex_me_t ex_me
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] alu_result;

	function automatic logic [xlen-1:0] fwd_mux(fwd_sel_t sel, logic [xlen-1:0] reg_val);
		case (sel)
			from_mem: return mem_result;
			from_wb: return wb_result;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = fwd_mux(rs1_sel, id_ex.rs1_data);
	assign rs2_val = fwd_mux(rs2_sel, id_ex.rs2_data);
	assign op_b = id_ex.use_imm ? id_ex.imm : rs2_val;

	always_comb begin
		case (id_ex.alu_op)
			sub: alu_result = op_a - op_b;
			pass_b: alu_result = op_b;
			default: alu_result = op_a + op_b;
		endcase
	end

	// beq taken
	assign redirect = id_ex.valid && id_ex.is_branch && (op_a == rs2_val);
	assign redirect_pc = id_ex.pc + id_ex.imm;

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_me.valid <= 1'b0;
			ex_me.is_load <= 1'b0;
			ex_me.is_store <= 1'b0;
			ex_me.rd_wena <= 1'b0;
		end else begin
			ex_me.valid <= id_ex.valid;
			ex_me.is_load <= id_ex.is_load;
			ex_me.is_store <= id_ex.is_store;
			ex_me.rd_wena <= id_ex.rd_wena;
			ex_me.pc <= id_ex.pc;
			ex_me.alu_result <= alu_result;
			ex_me.store_data <= rs2_val;
			ex_me.rd <= id_ex.rd;
		end
	end

endmodule

/* rtl/hazard_unit.sv */
// load-use stall and forwarding control
`timescale 1ns/100ps

module hazard_unit import core_pkg::*; (
	input logic [reg_addr_width-1:0] rs1,
	input logic [reg_addr_width-1:0] rs2,
	input logic decode_valid,
	input id_ex_t id_ex,
	input ex_me_t ex_me,
	input me_wb_t me_wb,
	output logic stall,
	output fwd_sel_t rs1_sel,
	output fwd_sel_t rs2_sel
);

	function automatic fwd_sel_t pick_source(logic [reg_addr_width-1:0] src);
		if (ex_me.valid && ex_me.rd_wena && !ex_me.is_load &&
				ex_me.rd != '0 && ex_me.rd == src)
			return from_mem;
		else if (me_wb.valid && me_wb.rd_wena && me_wb.rd != '0 && me_wb.rd == src)
			return from_wb;
		else
			return from_reg;
	endfunction

	// load data is not ready until writeback
	assign stall = decode_valid && id_ex.valid && id_ex.is_load && id_ex.rd != '0 &&
		(id_ex.rd == rs1 || id_ex.rd == rs2);

	assign rs1_sel = pick_source(id_ex.rs1);
	assign rs2_sel = pick_source(id_ex.rs2);

endmodule

/* rtl/decode_unit.sv */
// instruction decode stage
`timescale 1ns/100ps

module decode_unit import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic stall,
	input logic redirect,
	input if_id_t if_id,
	output logic [reg_addr_width-1:0] rs1,
	output logic [reg_addr_width-1:0] rs2,
	input logic [xlen-1:0] rs1_data,
	input logic [xlen-1:0] rs2_data,
	output id_ex_t id_ex
);

	id_ex_t dec;
	logic [6:0] opcode;

	assign opcode = if_id.inst.r_fmt.opcode;
	assign rs1 = if_id.inst.r_fmt.rs1;
	assign rs2 = if_id.inst.r_fmt.rs2;

	always_comb begin
		dec = '0;
		dec.valid = if_id.valid;
		dec.pc = if_id.pc;
		dec.rs1 = rs1;
		dec.rs2 = rs2;
		dec.rs1_data = rs1_data;
		dec.rs2_data = rs2_data;
		dec.alu_op = add;
		case (opcode)
			op_imm: begin
				dec.imm = {{(xlen-12){if_id.inst.i_fmt.imm[11]}}, if_id.inst.i_fmt.imm};
				dec.use_imm = 1'b1;
				dec.rd_wena = 1'b1;
			end
			op_reg: begin
				if (if_id.inst.r_fmt.funct7 == funct_sub)
					dec.alu_op = sub;
				dec.rd_wena = 1'b1;
			end
			op_load: begin
				dec.imm = {{(xlen-12){if_id.inst.i_fmt.imm[11]}}, if_id.inst.i_fmt.imm};
				dec.use_imm = 1'b1;
				dec.is_load = 1'b1;
				dec.rd_wena = 1'b1;
			end
			op_store: begin
				dec.imm = {{(xlen-12){if_id.inst.s_fmt.imm_hi[6]}},
					if_id.inst.s_fmt.imm_hi, if_id.inst.s_fmt.imm_lo};
				dec.use_imm = 1'b1;
				dec.is_store = 1'b1;
			end
			op_branch: begin
				dec.imm = {{(xlen-13){if_id.inst.b_fmt.imm12}}, if_id.inst.b_fmt.imm12,
					if_id.inst.b_fmt.imm11, if_id.inst.b_fmt.imm10_5,
					if_id.inst.b_fmt.imm4_1, 1'b0};
				dec.alu_op = sub;
				dec.is_branch = 1'b1;
			end
			// anything else retires as a no-op
			default: dec.alu_op = pass_b;
		endcase
		// rd only reported when written
		if (dec.rd_wena)
			dec.rd = if_id.inst.r_fmt.rd;
	end

	always_ff @(posedge clock) begin
		if (reset || stall || redirect) begin
			// bubble
			id_ex.valid <= 1'b0;
			id_ex.is_load <= 1'b0;
			id_ex.is_store <= 1'b0;
			id_ex.is_branch <= 1'b0;
			id_ex.rd_wena <= 1'b0;
		end else begin
			id_ex <= dec;
		end
	end

endmodule

/* rtl/regfile.sv */
// integer register file
`timescale 1ns/100ps

module regfile import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [reg_addr_width-1:0] rs1,
	input logic [reg_addr_width-1:0] rs2,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	input logic wena,
	input logic [reg_addr_width-1:0] waddr,
	input logic [xlen-1:0] wdata
);

	logic [xlen-1:0] regs [32];
	logic write_live;

	// x0 never takes a write
	assign write_live = wena && (waddr != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_live) begin
			regs[waddr] <= wdata;
		end
	end

	// same-cycle write is visible to decode
	assign rs1_data = (rs1 == '0) ? '0 : (write_live && waddr == rs1) ? wdata : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : (write_live && waddr == rs2) ? wdata : regs[rs2];

endmodule

/* rtl/fetch_unit.sv */
// instruction fetch stage
`timescale 1ns/100ps

module fetch_unit import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic stall,
	input logic redirect,
	input logic [xlen-1:0] redirect_pc,
	output logic [xlen-1:0] imem_addr,
	input logic [31:0] imem_data,
	output if_id_t if_id
);

	logic [xlen-1:0] pc;

	assign imem_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			if_id.valid <= 1'b0;
		end else if (redirect) begin
			// wrong-path word is dropped
			pc <= redirect_pc;
			if_id.valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + xlen'(4);
			if_id.valid <= 1'b1;
			if_id.pc <= pc;
			if_id.inst <= imem_data;
		end
	end

endmodule

/* rtl/core_pkg.sv */
// rv64 core shared definitions
package core_pkg;

	localparam int xlen = 64;
	localparam int reg_addr_width = 5;
	localparam logic [xlen-1:0] reset_pc = '0;

	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	// funct7 of SUB
	localparam logic [6:0] funct_sub = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// one instruction word, four format views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
	} inst_t;

	typedef enum logic [1:0] {
		add,
		sub,
		pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		from_reg,
		from_mem,
		from_wb
	} fwd_sel_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		inst_t inst;
	} if_id_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [reg_addr_width-1:0] rs1;
		logic [reg_addr_width-1:0] rs2;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] imm;
		alu_op_t alu_op;
		logic use_imm;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic rd_wena;
		logic [reg_addr_width-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] store_data;
		logic is_load;
		logic is_store;
		logic rd_wena;
		logic [reg_addr_width-1:0] rd;
	} ex_me_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] result;
		logic rd_wena;
		logic [reg_addr_width-1:0] rd;
	} me_wb_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic rd_wena;
		logic [reg_addr_width-1:0] rd;
		logic [xlen-1:0] data;
	} commit_t;

endpackage
